//--- Bender.yml
package:
  name: vga_scan

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/vga_pkg.sv
      - hdl/vga_scan_if.sv
      - hdl/vga_timing_gen.sv
      - hdl/vga_pixel_feed.sv
      - hdl/vga_timing_checker.sv
      - hdl/vga_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/vga_clk_gen.sv
      - dv/vga_tb.sv

//--- dv/vga_clk_gen.sv
`timescale 1ns/1ns

module vga_clk_gen (
   output logic clk,
   output logic arst_n
);

   localparam int HALF_PERIOD  = 50;
   localparam int RESET_CYCLES = 8;

   // Free-running pixel clock, 100 ns period
   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // Reset low for the first cycles
   // Released on a rising edge so the first active edge is the next one
   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
   end

endmodule

//--- dv/vga_tb.sv
`timescale 1ns/1ns

`include "vga_defs.svh"

module vga_tb;

   localparam int LINE_CLKS = `VGA_H_ACTIVE + `VGA_H_FP + `VGA_H_PW + `VGA_H_BP;
   localparam int FRAME_LINES = `VGA_V_ACTIVE + `VGA_V_FP + `VGA_V_PW + `VGA_V_BP;
   localparam int FRAME_CLKS = LINE_CLKS * FRAME_LINES;
   localparam int FRAME_PIXELS = `VGA_H_ACTIVE * `VGA_V_ACTIVE;
   localparam int NUM_PHASES = 5;

   logic        clk;
   logic        arst_n;
   logic [11:0] pix;
   logic        pix_valid;
   logic        pix_ready;
   logic [3:0]  vga_r;
   logic [3:0]  vga_g;
   logic [3:0]  vga_b;
   logic        vga_hsync;
   logic        vga_vsync;
   logic        vga_de;
   logic        underrun;
   logic        err_hsync;
   logic        err_vsync;
   logic        err_blank;
   logic        err_lines;
   logic        frame_ok;

   // Phase table, one row per phase
   // 36 is one frame plus a full buffer, 10 and 20 starve the buffer
   int phase_pixels [NUM_PHASES] = '{36, 64, 32, 10, 20};
   int phase_idle [NUM_PHASES] = '{3, 5, 0, 7, 2};
   bit phase_underrun [NUM_PHASES] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1};

   // Accepted pixels not yet seen on the pins
   logic [11:0] model_q [$];
   logic [11:0] head_pix;

   integer seed;
   int     cycle_count;
   int     timeout_limit;
   bit     underrun_seen;

   // Pin measurements
   logic hs_prev;
   logic vs_prev;
   bit   hs_seen;
   int   line_clks;
   int   low_clks;
   int   vs_falls;
   int   frame_pulses;

   vga_clk_gen u_clk_gen (
      .clk    (clk),
      .arst_n (arst_n)
   );

   vga_top uut (
      .clk       (clk),
      .arst_n    (arst_n),
      .pix       (pix),
      .pix_valid (pix_valid),
      .pix_ready (pix_ready),
      .vga_r     (vga_r),
      .vga_g     (vga_g),
      .vga_b     (vga_b),
      .vga_hsync (vga_hsync),
      .vga_vsync (vga_vsync),
      .vga_de    (vga_de),
      .underrun  (underrun),
      .err_hsync (err_hsync),
      .err_vsync (err_vsync),
      .err_blank (err_blank),
      .err_lines (err_lines),
      .frame_ok  (frame_ok)
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1, "stopping at first failure");
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         abort_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
      end
   endtask

   function automatic logic [11:0] next_pixel();
      next_pixel = 12'($random(seed));
   endfunction

   // Frames needed to show every pixel in the table
   function automatic int frames_in_table();
      int total;
      total = 0;
      for (int i = 0; i < NUM_PHASES; i++) begin
         total = total + (phase_pixels[i] + FRAME_PIXELS - 1) / FRAME_PIXELS;
      end
      frames_in_table = total;
   endfunction

   task automatic check_reset_values();
      check_value("vga_hsync", vga_hsync, 1'b1);
      check_value("vga_vsync", vga_vsync, 1'b1);
      check_value("vga_de", vga_de, 1'b0);
      check_value("pix_ready", pix_ready, 1'b1);
      check_value("vga_rgb", {vga_r, vga_g, vga_b}, 12'h000);
      check_value("underrun", underrun, 1'b0);
      check_value("frame_ok", frame_ok, 1'b0);
      check_value("status", {err_hsync, err_vsync, err_blank, err_lines}, 4'h0);
   endtask

   // Returns on the falling clock edge where vsync is first seen low
   task automatic wait_vsync_fall();
      logic prev;
      prev = vga_vsync;
      @(negedge clk);
      while (!(prev && !vga_vsync)) begin
         prev = vga_vsync;
         @(negedge clk);
      end
   endtask

   // Underrun is sticky, so a clear flag is only checked before the first starve
   task automatic check_underrun(input int p);
      if (phase_underrun[p]) begin
         check_value("underrun", underrun, 1'b1);
         underrun_seen = 1'b1;
      end else if (!underrun_seen) begin
         check_value("underrun", underrun, 1'b0);
      end
   endtask

   // Host side of the stream, holds each pixel until it is taken
   task automatic push_pixels(input int count, input bit start_empty);
      int accepted;
      bit taken;
      bit full_seen;
      accepted = 0;
      full_seen = 1'b0;
      pix <= next_pixel();
      pix_valid <= 1'b1;
      while (accepted < count) begin
         @(negedge clk);
         taken = pix_ready;
         // Empty buffer takes exactly its depth, then stalls the host
         if (start_empty && !full_seen) begin
            if (accepted < `VGA_FIFO_DEPTH) begin
               check_value("pix_ready", pix_ready, 1'b1);
            end else begin
               check_value("pix_ready", pix_ready, 1'b0);
               full_seen = 1'b1;
            end
         end
         @(posedge clk);
         if (taken) begin
            accepted = accepted + 1;
            if (accepted == count) begin
               pix_valid <= 1'b0;
            end else begin
               pix <= next_pixel();
            end
         end
      end
   endtask

   // Timeout guard
   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > timeout_limit) begin
         abort_run($sformatf("Timeout: run not finished after %0d clock cycles",
                             timeout_limit));
      end
   end

   // Pin monitor, samples mid-cycle
   always @(negedge clk) begin
      if (arst_n) begin
         if (vga_de && (model_q.size() > 0)) begin
            head_pix = model_q.pop_front();
            check_value("vga_rgb", {vga_r, vga_g, vga_b}, head_pix);
         end else begin
            // Blanking, or a starved active slot
            check_value("vga_rgb", {vga_r, vga_g, vga_b}, 12'h000);
         end
         check_value("err_hsync", err_hsync, 1'b0);
         check_value("err_vsync", err_vsync, 1'b0);
         check_value("err_blank", err_blank, 1'b0);
         check_value("err_lines", err_lines, 1'b0);
         line_clks = line_clks + 1;
         if (!vga_hsync) begin
            low_clks = low_clks + 1;
         end
         if (hs_prev && !vga_hsync) begin
            if (hs_seen) begin
               check_value("hsync_period", line_clks, LINE_CLKS);
            end
            hs_seen = 1'b1;
            line_clks = 0;
         end
         if (!hs_prev && vga_hsync) begin
            check_value("hsync_low_width", low_clks, `VGA_H_PW);
            low_clks = 0;
         end
         if (vs_prev && !vga_vsync) begin
            vs_falls = vs_falls + 1;
         end
         if (frame_ok) begin
            frame_pulses = frame_pulses + 1;
         end
         hs_prev = vga_hsync;
         vs_prev = vga_vsync;
         // Transfer taken at the coming rising edge
         if (pix_valid && pix_ready) begin
            model_q.push_back(pix);
         end
      end
   end

   initial begin
      bit start_empty;
      seed = 52;
      pix = '0;
      pix_valid = 1'b0;
      cycle_count = 0;
      underrun_seen = 1'b0;
      hs_prev = 1'b1;
      vs_prev = 1'b1;
      hs_seen = 1'b0;
      line_clks = 0;
      low_clks = 0;
      vs_falls = 0;
      frame_pulses = 0;
      timeout_limit = FRAME_CLKS * frames_in_table() + 200;

      wait (arst_n === 1'b1);
      @(negedge clk);
      check_reset_values();

      // Each phase starts in vertical blanking
      for (int p = 0; p < NUM_PHASES; p++) begin
         wait_vsync_fall();
         if (p > 0) begin
            check_underrun(p - 1);
         end
         start_empty = (model_q.size() == 0);
         repeat (phase_idle[p] + 1) @(posedge clk);
         push_pixels(phase_pixels[p], start_empty);
      end

      // Last frame drains the buffer
      wait_vsync_fall();
      check_underrun(NUM_PHASES - 1);
      check_value("model_queue_size", model_q.size(), 0);

      // Let the last frame pulse through the checker
      repeat (8) @(negedge clk);
      check_value("frame_ok_pulses", frame_pulses, vs_falls - 2);
      check_value("checked_frames_enough", (frame_pulses >= 4), 1'b1);

      $display("test passed");
      $finish;
   end

endmodule

//--- hdl/vga_pixel_feed.sv
`timescale 1ns/1ns

`include "vga_defs.svh"

module vga_pixel_feed (
   input  logic             clk,
   input  logic             arst_n,
   input  vga_pkg::vga_rgb_t pix,
   input  logic             pix_valid,
   output logic             pix_ready,
   output vga_pkg::vga_rgb_t rgb,
   output logic             hsync,
   output logic             vsync,
   output logic             de,
   output logic             underrun,
   vga_scan_if.feed         scan
);
   import vga_pkg::*;

   localparam int DEPTH = `VGA_FIFO_DEPTH;
   localparam int PW = $clog2(DEPTH);

   // FIFO storage and pointers
   vga_rgb_t    mem [DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [PW:0]   count;

   logic empty;
   logic push;
   logic pop;
   logic go;
   logic starve;
   // Output starts on a line boundary
   logic armed;

   // Pixel taken on fetch, one stage ahead of the pins
   vga_rgb_t px_q;

   assign empty     = (count == '0);
   assign pix_ready = (count != (PW+1)'(DEPTH));
   assign push      = pix_valid && pix_ready;

   // Draining may begin at any line start with data waiting
   assign go     = armed || (scan.line_start && !empty);
   assign pop    = scan.fetch && go && !empty;
   assign starve = scan.fetch && go && empty;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= pix;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         armed    <= 1'b0;
         underrun <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leaves count alone
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
         if (go) begin
            armed <= 1'b1;
         end
         // Sticky until reset
         if (starve) begin
            underrun <= 1'b1;
         end
      end
   end

   // Black on an empty fetch and outside the window
   always_ff @(posedge clk) begin
      px_q <= pop ? mem[rd_ptr] : '0;
   end

   // Pin register, colour and timing leave together
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rgb   <= '0;
         de    <= 1'b0;
         hsync <= 1'b1;
         vsync <= 1'b1;
      end else begin
         rgb   <= scan.de ? px_q : '0;
         de    <= scan.de;
         hsync <= scan.hsync;
         vsync <= scan.vsync;
      end
   end

endmodule

//--- hdl/vga_pkg.sv
package vga_pkg;

   // One pixel, 4 bits per channel
   typedef struct packed {
      logic [3:0] r;
      logic [3:0] g;
      logic [3:0] b;
   } vga_rgb_t;

   // Sticky error flags of the pin checker
   typedef struct packed {
      logic err_hsync;
      logic err_vsync;
      logic err_blank;
      logic err_lines;
   } vga_status_t;

   // Checker sync-up sequence
   // First vsync pulse is only used to lock on
   typedef enum logic [1:0] {
      CHK_WAIT_LOW,
      CHK_WAIT_HIGH,
      CHK_RUN
   } chk_state_e;

endpackage

//--- hdl/vga_scan_if.sv
`timescale 1ns/1ns

interface vga_scan_if;

   // Pixel for the next clock is needed
   logic fetch;
   // Display enable for this clock
   logic de;
   // Active-low syncs, aligned with de
   logic hsync;
   logic vsync;
   // First pixel slot of a line, aligned with fetch
   logic line_start;

   modport gen (
      output fetch, de, hsync, vsync, line_start
   );

   modport feed (
      input fetch, de, hsync, vsync, line_start
   );

endinterface

//--- hdl/vga_timing_checker.sv
`timescale 1ns/1ns

`include "vga_defs.svh"

module vga_timing_checker (
   input  logic                clk,
   input  logic                arst_n,
   input  vga_pkg::vga_rgb_t   rgb,
   input  logic                hsync,
   input  logic                vsync,
   input  logic                de,
   output vga_pkg::vga_status_t status,
   output logic                frame_ok
);
   import vga_pkg::*;

   localparam int H_TOTAL = `VGA_H_ACTIVE + `VGA_H_FP + `VGA_H_PW + `VGA_H_BP;
   localparam int V_TOTAL = `VGA_V_ACTIVE + `VGA_V_FP + `VGA_V_PW + `VGA_V_BP;
   localparam int HCW = $clog2(H_TOTAL + 1);
   localparam int VCW = $clog2(V_TOTAL + 1);

   chk_state_e state;

   // Pins sampled once, then one more stage for edges
   vga_rgb_t rgb_d;
   logic     de_d;
   logic     hs_d;
   logic     hs_dd;
   logic     vs_d;
   logic     vs_dd;

   // Run lengths of the level before each edge
   logic [HCW-1:0] h_run;
   logic [VCW-1:0] v_run;
   logic [VCW-1:0] lines;

   logic hs_edge;
   logic hs_fall;
   logic vs_edge;
   logic vs_fall;
   logic bad_h;
   logic bad_v;
   logic bad_blank;
   logic bad_lines;
   logic run;
   // First checked frame is still partial
   logic first_done;
   logic frame_err;

   assign hs_edge = hs_d ^ hs_dd;
   assign hs_fall = hs_dd && !hs_d;
   assign vs_edge = vs_d ^ vs_dd;
   assign vs_fall = vs_dd && !vs_d;
   assign run     = (state == CHK_RUN);

   // Rising edge closes a pulse, falling edge closes the gap
   assign bad_h = hs_edge && (hs_d ? (h_run != HCW'(`VGA_H_PW))
                                   : (h_run != HCW'(H_TOTAL - `VGA_H_PW)));
   assign bad_v = vs_edge && (vs_d ? (v_run != VCW'(`VGA_V_PW))
                                   : (v_run != VCW'(V_TOTAL - `VGA_V_PW)));
   assign bad_blank = !de_d && (rgb_d != '0);
   assign bad_lines = vs_fall && (lines != VCW'(V_TOTAL));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rgb_d <= '0;
         de_d  <= 1'b0;
         hs_d  <= 1'b1;
         hs_dd <= 1'b1;
         vs_d  <= 1'b1;
         vs_dd <= 1'b1;
      end else begin
         rgb_d <= rgb;
         de_d  <= de;
         hs_d  <= hsync;
         hs_dd <= hs_d;
         vs_d  <= vsync;
         vs_dd <= vs_d;
      end
   end

   // Lock onto the first full vsync pulse
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= CHK_WAIT_LOW;
      end else begin
         case (state)
            CHK_WAIT_LOW:  if (!vs_d) state <= CHK_WAIT_HIGH;
            CHK_WAIT_HIGH: if (vs_d) state <= CHK_RUN;
            default:       state <= CHK_RUN;
         endcase
      end
   end

   // Counters run in every state so the first RUN edge sees a full run
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         h_run <= '0;
         v_run <= '0;
         lines <= '0;
      end else begin
         if (hs_edge) begin
            h_run <= HCW'(1);
         end else if (h_run != '1) begin
            h_run <= h_run + 1'b1;
         end
         // Vertical runs counted in hsync falls
         if (vs_edge) begin
            v_run <= VCW'(hs_fall);
         end else if (hs_fall && (v_run != '1)) begin
            v_run <= v_run + 1'b1;
         end
         if (vs_fall) begin
            lines <= VCW'(hs_fall);
         end else if (hs_fall && (lines != '1)) begin
            lines <= lines + 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         status     <= '0;
         frame_ok   <= 1'b0;
         first_done <= 1'b0;
         frame_err  <= 1'b0;
      end else begin
         frame_ok <= 1'b0;
         if (run) begin
            if (bad_h)     status.err_hsync <= 1'b1;
            if (bad_v)     status.err_vsync <= 1'b1;
            if (bad_blank) status.err_blank <= 1'b1;
            if (bad_lines) status.err_lines <= 1'b1;
            if (vs_fall) begin
               // Frame boundary, report and start a fresh frame
               frame_ok   <= first_done && !frame_err &&
                             !(bad_h || bad_v || bad_blank || bad_lines);
               first_done <= 1'b1;
               frame_err  <= 1'b0;
            end else if (bad_h || bad_v || bad_blank) begin
               frame_err <= 1'b1;
            end
         end
      end
   end

endmodule

//--- hdl/vga_timing_gen.sv
`timescale 1ns/1ns

`include "vga_defs.svh"

module vga_timing_gen (
   input logic clk,
   input logic arst_n,
   vga_scan_if.gen scan
);

   localparam int H_TOTAL = `VGA_H_ACTIVE + `VGA_H_FP + `VGA_H_PW + `VGA_H_BP;
   localparam int V_TOTAL = `VGA_V_ACTIVE + `VGA_V_FP + `VGA_V_PW + `VGA_V_BP;
   localparam int H_SYNC_START = `VGA_H_ACTIVE + `VGA_H_FP;
   localparam int V_SYNC_START = `VGA_V_ACTIVE + `VGA_V_FP;
   localparam int HW = $clog2(H_TOTAL);
   localparam int VW = $clog2(V_TOTAL);

   // Scan position
   logic [HW-1:0] h_cnt;
   logic [VW-1:0] v_cnt;

   logic h_last;
   logic v_last;
   logic h_act;
   logic v_act;
   logic h_pulse;
   logic v_pulse;

   // Syncs one stage early, in step with fetch
   logic hs_pre;
   logic vs_pre;

   assign h_last = (h_cnt == HW'(H_TOTAL - 1));
   assign v_last = (v_cnt == VW'(V_TOTAL - 1));

   // Window decodes on the current position
   assign h_act   = (h_cnt < HW'(`VGA_H_ACTIVE));
   assign v_act   = (v_cnt < VW'(`VGA_V_ACTIVE));
   assign h_pulse = (h_cnt >= HW'(H_SYNC_START)) &&
                    (h_cnt < HW'(H_SYNC_START + `VGA_H_PW));
   // Vertical pulse spans whole lines
   assign v_pulse = (v_cnt >= VW'(V_SYNC_START)) &&
                    (v_cnt < VW'(V_SYNC_START + `VGA_V_PW));

   // Pixel and line counters, free running
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else begin
         if (h_last) begin
            h_cnt <= '0;
            // Line advances once per line wrap
            if (v_last) begin
               v_cnt <= '0;
            end else begin
               v_cnt <= v_cnt + 1'b1;
            end
         end else begin
            h_cnt <= h_cnt + 1'b1;
         end
      end
   end

   // First stage, fetch request and early syncs
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         scan.fetch      <= 1'b0;
         scan.line_start <= 1'b0;
         hs_pre          <= 1'b1;
         vs_pre          <= 1'b1;
      end else begin
         scan.fetch      <= h_act && v_act;
         scan.line_start <= (h_cnt == '0);
         hs_pre          <= !h_pulse;
         vs_pre          <= !v_pulse;
      end
   end

   // Second stage, de lags fetch by one clock
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         scan.de    <= 1'b0;
         scan.hsync <= 1'b1;
         scan.vsync <= 1'b1;
      end else begin
         scan.de    <= scan.fetch;
         scan.hsync <= hs_pre;
         scan.vsync <= vs_pre;
      end
   end

endmodule

//--- hdl/vga_top.sv
`timescale 1ns/1ns

module vga_top (
   input  logic        clk,
   input  logic        arst_n,
   input  logic [11:0] pix,
   input  logic        pix_valid,
   output logic        pix_ready,
   output logic [3:0]  vga_r,
   output logic [3:0]  vga_g,
   output logic [3:0]  vga_b,
   output logic        vga_hsync,
   output logic        vga_vsync,
   output logic        vga_de,
   output logic        underrun,
   output logic        err_hsync,
   output logic        err_vsync,
   output logic        err_blank,
   output logic        err_lines,
   output logic        frame_ok
);
   import vga_pkg::*;

   vga_rgb_t    pix_rgb;
   vga_rgb_t    rgb;
   vga_status_t status;

   // Packed pixel is r, g, b from the top bits down
   assign pix_rgb = pix;

   assign vga_r = rgb.r;
   assign vga_g = rgb.g;
   assign vga_b = rgb.b;

   assign err_hsync = status.err_hsync;
   assign err_vsync = status.err_vsync;
   assign err_blank = status.err_blank;
   assign err_lines = status.err_lines;

   // Scan timing from generator to pixel buffer
   vga_scan_if scan_if ();

   vga_timing_gen u_timing_gen (
      .clk    (clk),
      .arst_n (arst_n),
      .scan   (scan_if.gen)
   );

   vga_pixel_feed u_pixel_feed (
      .clk       (clk),
      .arst_n    (arst_n),
      .pix       (pix_rgb),
      .pix_valid (pix_valid),
      .pix_ready (pix_ready),
      .rgb       (rgb),
      .hsync     (vga_hsync),
      .vsync     (vga_vsync),
      .de        (vga_de),
      .underrun  (underrun),
      .scan      (scan_if.feed)
   );

   // Checker sees only the output pins
   vga_timing_checker u_timing_checker (
      .clk      (clk),
      .arst_n   (arst_n),
      .rgb      (rgb),
      .hsync    (vga_hsync),
      .vsync    (vga_vsync),
      .de       (vga_de),
      .status   (status),
      .frame_ok (frame_ok)
   );

endmodule

//--- include/vga_defs.svh
`ifndef VGA_DEFS_SVH
`define VGA_DEFS_SVH

// Horizontal intervals, in pixel clocks
// Line order is active, front porch, sync pulse, back porch
`define VGA_H_ACTIVE 8
`define VGA_H_FP 2
`define VGA_H_PW 3
`define VGA_H_BP 3

// Vertical intervals, in lines
// Frame order matches the line order above
`define VGA_V_ACTIVE 4
`define VGA_V_FP 1
`define VGA_V_PW 2
`define VGA_V_BP 2

// Pixel buffer depth in entries
`define VGA_FIFO_DEPTH 4

`endif

//--- vga_scan.f
+incdir+include
hdl/vga_pkg.sv
hdl/vga_scan_if.sv
hdl/vga_timing_gen.sv
hdl/vga_pixel_feed.sv
hdl/vga_timing_checker.sv
hdl/vga_top.sv
dv/vga_clk_gen.sv
dv/vga_tb.sv
